/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// width of one data word and of an address
`define CORE_XLEN 32

`define CORE_REG_AW 5
`define CORE_NUM_REGS 32

`define CORE_RESET_PC 32'h0000_0000

`endif

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // major opcodes still decoded by the core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // alu funct3 shared by op and op_imm
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // I imm in this view is {sign, imm_10_5, imm_4_0}
  typedef struct packed {
    logic       sign;
    logic [5:0] imm_10_5;
    logic [4:0] imm_4_0;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } ib_fmt_t;

  typedef union packed {
    r_fmt_t  r_fmt;
    ib_fmt_t ib_fmt;
  } insn_u;

endpackage

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI
  } alu_op_e;

  typedef struct packed {
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rd;
    alu_op_e                 alu_op;
    // operand b from the immediate instead of rs2
    logic                    b_sel_imm;
    logic [`CORE_XLEN-1:0]   imm;
    logic                    branch;
    logic [2:0]              br_funct3;
    logic                    writes_rd;
    logic                    halt;
    logic                    illegal;
  } dec_op_t;

  typedef struct packed {
    logic                  req;
    logic [`CORE_XLEN-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic                  ack;
    logic [`CORE_XLEN-1:0] insn;
  } fetch_rsp_t;

  // register write bus that doubles as the trace port
  typedef struct packed {
    logic                    valid;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   data;
  } wb_t;

endpackage

`default_nettype wire

/* logic/insn_decode.sv */
`default_nettype none
`include "core_cfg.svh"

module insn_decode (
  input  rv_isa_pkg::insn_u insn,
  output core_pkg::dec_op_t dec
);

  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [2:0]            f3;
  logic                  f7_base;
  logic                  f7_alt;
  logic                  sys_zero;

  assign f3       = insn.r_fmt.funct3;
  assign f7_base  = insn.r_fmt.funct7 == rv_isa_pkg::F7_BASE;
  assign f7_alt   = insn.r_fmt.funct7 == rv_isa_pkg::F7_ALT;
  // ecall has every field above the opcode at zero
  assign sys_zero = {insn.r_fmt.funct7, insn.r_fmt.rs2, insn.r_fmt.rs1,
                     insn.r_fmt.funct3, insn.r_fmt.rd} == '0;

  // immediates from the two views
  assign imm_i = {{(`CORE_XLEN-11){insn.ib_fmt.sign}}, insn.ib_fmt.imm_10_5,
                  insn.ib_fmt.imm_4_0};
  assign imm_b = {{(`CORE_XLEN-12){insn.ib_fmt.sign}}, insn.ib_fmt.imm_11,
                  insn.ib_fmt.imm_10_5, insn.ib_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.r_fmt.funct7, insn.r_fmt.rs2, insn.r_fmt.rs1,
                  insn.r_fmt.funct3, 12'h000};

  always_comb begin
    dec           = '0;
    dec.rs1       = insn.r_fmt.rs1;
    dec.rs2       = insn.r_fmt.rs2;
    dec.rd        = insn.r_fmt.rd;
    dec.alu_op    = core_pkg::ALU_ADD;
    dec.br_funct3 = f3;

    // funct3 maps to the same alu op for register and immediate forms
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: dec.alu_op = core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     dec.alu_op = core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     dec.alu_op = core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    dec.alu_op = core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     dec.alu_op = core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: dec.alu_op = f7_alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      dec.alu_op = core_pkg::ALU_OR;
      default:                dec.alu_op = core_pkg::ALU_AND;
    endcase

    case (insn.r_fmt.opcode)
      rv_isa_pkg::OPC_LUI: begin
        dec.alu_op    = core_pkg::ALU_LUI;
        dec.b_sel_imm = 1'b1;
        dec.imm       = imm_u;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        dec.b_sel_imm = 1'b1;
        dec.imm       = imm_i;
        dec.writes_rd = 1'b1;
        // shift immediates carry funct7 in the upper bits
        if ((f3 == rv_isa_pkg::F3_SLL && !f7_base) ||
            (f3 == rv_isa_pkg::F3_SRL_SRA && !(f7_base || f7_alt))) begin
          dec.illegal = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP: begin
        dec.writes_rd = 1'b1;
        if (f3 == rv_isa_pkg::F3_ADD_SUB && f7_alt) begin
          dec.alu_op = core_pkg::ALU_SUB;
        end
        // only add/sub and srl/sra have an alternate funct7
        if (!(f7_base || (f7_alt && (f3 == rv_isa_pkg::F3_ADD_SUB ||
                                     f3 == rv_isa_pkg::F3_SRL_SRA)))) begin
          dec.illegal = 1'b1;
        end
      end
      rv_isa_pkg::OPC_BRANCH: begin
        dec.branch = 1'b1;
        dec.imm    = imm_b;
        // funct3 010 and 011 are not branches
        dec.illegal = f3 == 3'b010 || f3 == 3'b011;
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        dec.halt    = sys_zero;
        dec.illegal = !sys_zero;
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* logic/int_alu.sv */
`default_nettype none
`include "core_cfg.svh"

module int_alu (
  input  core_pkg::dec_op_t     dec,
  input  logic [`CORE_XLEN-1:0] rs1_data,
  input  logic [`CORE_XLEN-1:0] rs2_data,
  output logic [`CORE_XLEN-1:0] result
);

  logic [`CORE_XLEN-1:0] op_b;
  logic [4:0]            shamt;
  logic                  lt_signed;
  logic                  lt_unsigned;

  assign op_b = dec.b_sel_imm ? dec.imm : rs2_data;

  // shifts use the low 5 bits of either operand source
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  always_comb begin
    case (dec.alu_op)
      core_pkg::ALU_ADD:  result = rs1_data + op_b;
      core_pkg::ALU_SUB:  result = rs1_data - op_b;
      core_pkg::ALU_SLL:  result = rs1_data << shamt;
      core_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
      core_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
      core_pkg::ALU_XOR:  result = rs1_data ^ op_b;
      core_pkg::ALU_SRL:  result = rs1_data >> shamt;
      core_pkg::ALU_SRA:  result = $signed(rs1_data) >>> shamt;
      core_pkg::ALU_OR:   result = rs1_data | op_b;
      core_pkg::ALU_AND:  result = rs1_data & op_b;
      // upper immediate already shifted by decode
      core_pkg::ALU_LUI:  result = dec.imm;
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`default_nettype none
`include "core_cfg.svh"

module branch_unit (
  input  core_pkg::dec_op_t     dec,
  input  logic [`CORE_XLEN-1:0] pc,
  input  logic [`CORE_XLEN-1:0] rs1_data,
  input  logic [`CORE_XLEN-1:0] rs2_data,
  output logic [`CORE_XLEN-1:0] next_pc
);

  localparam logic [`CORE_XLEN-1:0] INSN_BYTES = 4;

  logic taken;

  always_comb begin
    case (dec.br_funct3)
      rv_isa_pkg::F3_BEQ:  taken = rs1_data == rs2_data;
      rv_isa_pkg::F3_BNE:  taken = rs1_data != rs2_data;
      rv_isa_pkg::F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_isa_pkg::F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_isa_pkg::F3_BLTU: taken = rs1_data < rs2_data;
      rv_isa_pkg::F3_BGEU: taken = rs1_data >= rs2_data;
      default:             taken = 1'b0;
    endcase
  end

  // non-branches fall through to the next word
  assign next_pc = (dec.branch && taken) ? pc + dec.imm : pc + INSN_BYTES;

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none
`include "core_cfg.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`CORE_REG_AW-1:0] rs1,
  input  logic [`CORE_REG_AW-1:0] rs2,
  output logic [`CORE_XLEN-1:0]   rs1_data,
  output logic [`CORE_XLEN-1:0]   rs2_data,
  input  core_pkg::wb_t           wb
);

  // x0 has no storage
  logic [`CORE_XLEN-1:0] regs [1:`CORE_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* logic/sequencer.sv */
`default_nettype none
`include "core_cfg.svh"

module sequencer (
  input  logic                  clk,
  input  logic                  rst,
  output core_pkg::fetch_req_t  fetch,
  input  core_pkg::fetch_rsp_t  fetch_rsp,
  output rv_isa_pkg::insn_u     insn,
  input  core_pkg::dec_op_t     dec,
  input  logic [`CORE_XLEN-1:0] result,
  input  logic [`CORE_XLEN-1:0] next_pc,
  output logic [`CORE_XLEN-1:0] pc,
  output core_pkg::wb_t         wb,
  output logic                  halt,
  output logic                  illegal
);

  typedef enum logic [1:0] {S_REQ, S_WAIT_LOW, S_EXEC, S_HALT} state_e;

  state_e state;
  logic   req;
  logic   stop;
  logic   take_insn;

  assign stop      = dec.halt || dec.illegal;
  assign take_insn = state == S_REQ && req && fetch_rsp.ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_REQ;
      req     <= 1'b0;
      pc      <= `CORE_RESET_PC;
      halt    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        S_REQ: begin
          // req held with a stable pc until the first ack
          req <= !take_insn;
          if (take_insn) begin
            state <= S_WAIT_LOW;
          end
        end
        S_WAIT_LOW: begin
          if (!fetch_rsp.ack) begin
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (stop) begin
            state   <= S_HALT;
            halt    <= 1'b1;
            illegal <= dec.illegal;
          end else begin
            pc    <= next_pc;
            req   <= 1'b1;
            state <= S_REQ;
          end
        end
        S_HALT: state <= S_HALT;
      endcase
    end
  end

  // instruction latch
  always_ff @(posedge clk) begin
    if (take_insn) begin
      insn <= fetch_rsp.insn;
    end
  end

  always_comb begin
    fetch.req = req;
    fetch.pc  = pc;
    // write only in execute, and never for a halting instruction
    wb.valid  = state == S_EXEC && dec.writes_rd && !stop;
    wb.rd     = dec.rd;
    wb.data   = result;
  end

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`default_nettype none
`include "core_cfg.svh"

module rv_core (
  input  logic                 clk,
  input  logic                 rst,
  output core_pkg::fetch_req_t fetch,
  input  core_pkg::fetch_rsp_t fetch_rsp,
  output core_pkg::wb_t        wb,
  output logic                 halt,
  output logic                 illegal
);

  rv_isa_pkg::insn_u     insn;
  core_pkg::dec_op_t     dec;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic [`CORE_XLEN-1:0] result;
  logic [`CORE_XLEN-1:0] next_pc;
  logic [`CORE_XLEN-1:0] pc;

  sequencer seq_i (
    .clk       (clk),
    .rst       (rst),
    .fetch     (fetch),
    .fetch_rsp (fetch_rsp),
    .insn      (insn),
    .dec       (dec),
    .result    (result),
    .next_pc   (next_pc),
    .pc        (pc),
    .wb        (wb),
    .halt      (halt),
    .illegal   (illegal)
  );

  insn_decode dec_i (
    .insn (insn),
    .dec  (dec)
  );

  // write bus also leaves the core as the trace port
  reg_file rf_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  int_alu alu_i (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result)
  );

  branch_unit br_i (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .next_pc  (next_pc)
  );

endmodule

`default_nettype wire

/* bench/rv_core_assert.sv */
`default_nettype none

module rv_core_assert (
  input logic                 clk,
  input logic                 rst,
  input core_pkg::fetch_req_t fetch,
  input core_pkg::fetch_rsp_t fetch_rsp,
  input logic                 halt
);

  // responder only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(fetch_rsp.ack) |-> fetch.req)
    else $error("ack rose without a pending fetch request");

  // request and pc held until acknowledged
  req_held: assert property (@(posedge clk) disable iff (rst)
    (fetch.req && !fetch_rsp.ack) |=> (fetch.req && $stable(fetch.pc)))
    else $error("fetch request or pc changed before ack");

  halt_no_req: assert property (@(posedge clk) disable iff (rst)
    halt |-> !fetch.req)
    else $error("fetch request raised while halted");

endmodule

bind rv_core rv_core_assert assert_i (
  .clk       (clk),
  .rst       (rst),
  .fetch     (fetch),
  .fetch_rsp (fetch_rsp),
  .halt      (halt)
);

`default_nettype wire

/* bench/rv_core_tb.sv */
`default_nettype none
`include "core_cfg.svh"

module rv_core_tb;

  typedef struct packed {
    core_pkg::wb_t wb;
    logic [31:0]   next_pc;
    logic          halt;
    logic          illegal;
  } exp_t;

  logic                 clk;
  logic                 rst;
  core_pkg::fetch_req_t fetch;
  core_pkg::fetch_rsp_t fetch_rsp;
  core_pkg::wb_t        wb;
  logic                 halt;
  logic                 illegal;

  logic [31:0] prog [128];
  logic [31:0] model_rf [32];
  logic [31:0] lcg_state;
  int          max_delay;
  int          delay_cnt;
  logic [63:0] trace_q [$];
  logic [63:0] zero_delay_q [$];

  rv_core dut_i (
    .clk       (clk),
    .rst       (rst),
    .fetch     (fetch),
    .fetch_rsp (fetch_rsp),
    .wb        (wb),
    .halt      (halt),
    .illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int pick_delay();
    if (max_delay == 0) begin
      return 0;
    end
    return int'(lcg_next() >> 16) % (max_delay + 1);
  endfunction

  // instruction memory responder
  always @(posedge clk) begin
    if (rst) begin
      fetch_rsp <= '0;
      delay_cnt <= 0;
    end else if (fetch.req && !fetch_rsp.ack) begin
      if (delay_cnt == 0) begin
        fetch_rsp.ack  <= 1'b1;
        fetch_rsp.insn <= prog[fetch.pc[8:2]];
      end else begin
        delay_cnt <= delay_cnt - 1;
      end
    end else if (!fetch.req && fetch_rsp.ack) begin
      fetch_rsp <= '0;
      delay_cnt <= pick_delay();
    end
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // expected outcome of one instruction
  function automatic exp_t ref_exec(logic [31:0] w, logic [31:0] rf [32], logic [31:0] pc);
    exp_t        e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic        taken;
    e       = '0;
    a       = rf[w[19:15]];
    b       = rf[w[24:20]];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    e.next_pc = pc + 32'd4;
    e.wb.rd   = w[11:7];
    case (w[6:0])
      7'h37: begin
        e.wb.valid = 1'b1;
        e.wb.data  = {w[31:12], 12'h000};
      end
      7'h13: begin
        e.wb.valid = 1'b1;
        e.wb.data  = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
        if ((w[14:12] == 3'd1 && w[31:25] != 7'h00) ||
            (w[14:12] == 3'd5 && w[31:25] != 7'h00 && w[31:25] != 7'h20)) begin
          e.illegal = 1'b1;
        end
      end
      7'h33: begin
        e.wb.valid = 1'b1;
        e.wb.data  = alu_ref(w[14:12], w[30], a, b);
        if (!(w[31:25] == 7'h00 ||
              (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5)))) begin
          e.illegal = 1'b1;
        end
      end
      7'h63: begin
        case (w[14:12])
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        e.illegal = w[14:12] == 3'd2 || w[14:12] == 3'd3;
        if (taken) begin
          e.next_pc = pc + imm_b;
        end
      end
      7'h73: begin
        e.halt    = 1'b1;
        e.illegal = w[31:7] != '0;
      end
      default: e.illegal = 1'b1;
    endcase
    if (e.illegal) begin
      e.halt     = 1'b1;
      e.wb.valid = 1'b0;
    end
    return e;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // no register write may show up while waiting on the fetch
  task automatic wait_req(input logic level);
    int n;
    n = 0;
    while (fetch.req !== level) begin
      @(negedge clk);
      n++;
      check("wb.valid", {31'b0, wb.valid}, 32'd0);
      if (n > 40) begin
        fail_run("fetch request did not change within 40 cycles");
      end
    end
  endtask

  task automatic wait_wb();
    int n;
    n = 0;
    while (wb.valid !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > 40) begin
        fail_run("register write did not appear within 40 cycles");
      end
    end
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (halt !== 1'b1) begin
      @(negedge clk);
      n++;
      check("wb.valid", {31'b0, wb.valid}, 32'd0);
      if (n > 40) begin
        fail_run("core did not halt within 40 cycles");
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("fetch.req", {31'b0, fetch.req}, 32'd0);
    check("wb.valid", {31'b0, wb.valid}, 32'd0);
    check("halt", {31'b0, halt}, 32'd0);
    check("illegal", {31'b0, illegal}, 32'd0);
  endtask

  task automatic run_program();
    logic [31:0] pc;
    exp_t        e;
    foreach (model_rf[i]) model_rf[i] = '0;
    trace_q.delete();
    pc = `CORE_RESET_PC;
    apply_reset();
    for (int step = 0; step < 500; step++) begin
      wait_req(1'b1);
      check("fetch.pc", fetch.pc, pc);
      e = ref_exec(prog[pc[8:2]], model_rf, pc);
      wait_req(1'b0);
      if (e.halt) begin
        wait_halt();
        check("illegal", {31'b0, illegal}, {31'b0, e.illegal});
        repeat (30) begin
          @(negedge clk);
          if (fetch.req) begin
            fail_run("fetch request raised after halt");
          end
        end
        return;
      end
      if (e.wb.valid) begin
        wait_wb();
        check("wb.rd", {27'b0, wb.rd}, {27'b0, e.wb.rd});
        check("wb.data", wb.data, e.wb.data);
        if (e.wb.rd != 0) begin
          model_rf[e.wb.rd] = e.wb.data;
        end
        trace_q.push_back({27'b0, wb.rd, wb.data});
      end
      pc = e.next_pc;
    end
    fail_run("program did not halt within 500 instructions");
  endtask

  task automatic clear_prog();
    // unused words load their own index into x7
    foreach (prog[i]) prog[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd7);
  endtask

  task automatic build_alu_prog();
    int          k;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] r;
    clear_prog();
    k = 0;
    for (int x = 1; x < 16; x++) begin
      r = lcg_next();
      prog[k] = {r[31:12], 5'(x), 7'b0110111};
      r = lcg_next();
      prog[k + 1] = enc_i(r[19:8], 5'(x), 3'd0, 5'(x));
      k += 2;
    end
    for (int n = 0; n < 60; n++) begin
      r  = lcg_next();
      f3 = r[10:8];
      f7 = (r[11] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      if (r[31]) begin
        prog[k] = enc_r(f7, {1'b0, r[15:12]}, {1'b0, r[19:16]}, f3, {1'b0, r[23:20]});
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
        prog[k] = enc_i({(f3 == 3'd5) ? f7 : 7'h00, r[28:24]}, {1'b0, r[19:16]}, f3,
                        {1'b0, r[23:20]});
      end else begin
        prog[k] = enc_i(r[27:16], {1'b0, r[15:12]}, f3, {1'b0, r[23:20]});
      end
      k++;
    end
    // write to x0, then read it back as both operands
    prog[k] = enc_i(12'd77, 5'd1, 3'd0, 5'd0);
    prog[k + 1] = enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd16);
    prog[k + 2] = enc_r(7'h00, 5'd0, 5'd1, 3'd6, 5'd17);
    prog[k + 3] = 32'h0000_0073;
  endtask

  task automatic build_branch_prog();
    int         k;
    logic [2:0] f3;
    int         tk_a [6] = '{1, 1, 2, 1, 1, 2};
    int         tk_b [6] = '{3, 2, 1, 2, 2, 1};
    int         nt_a [6] = '{1, 1, 1, 2, 2, 1};
    int         nt_b [6] = '{2, 3, 2, 1, 1, 2};
    logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [11:0] v;
    clear_prog();
    v = 12'(int'(lcg_next() >> 20) % 1000 + 1);
    // x1 == x3 positive, x2 negative
    prog[0] = enc_i(v, 5'd0, 3'd0, 5'd1);
    prog[1] = enc_i(v, 5'd0, 3'd0, 5'd3);
    prog[2] = enc_i(12'(-(int'(lcg_next() >> 20) % 1000 + 1)), 5'd0, 3'd0, 5'd2);
    k = 3;
    for (int c = 0; c < 6; c++) begin
      f3 = conds[c];
      prog[k] = enc_b(13'd8, 5'(tk_b[c]), 5'(tk_a[c]), f3);
      k += 2;
      // hop over, branch back, hop out
      prog[k] = enc_b(13'd12, 5'd3, 5'd1, 3'd0);
      prog[k + 1] = enc_b(13'd12, 5'd3, 5'd1, 3'd0);
      prog[k + 3] = enc_b(13'h1ff8, 5'(tk_b[c]), 5'(tk_a[c]), f3);
      k += 4;
      prog[k] = enc_b(13'd8, 5'(nt_b[c]), 5'(nt_a[c]), f3);
      prog[k + 1] = enc_b(13'h1ff8, 5'(nt_b[c]), 5'(nt_a[c]), f3);
      k += 2;
    end
    prog[k] = 32'h0000_0073;
  endtask

  initial begin
    rst       = 1'b1;
    fetch_rsp = '0;
    lcg_state = 32'd32;
    max_delay = 0;
    build_alu_prog();
    run_program();
    zero_delay_q = trace_q;
    max_delay = 3;
    run_program();
    check("trace.length", trace_q.size(), zero_delay_q.size());
    foreach (zero_delay_q[i]) begin
      check("trace.rd", trace_q[i][63:32], zero_delay_q[i][63:32]);
      check("trace.data", trace_q[i][31:0], zero_delay_q[i][31:0]);
    end
    build_branch_prog();
    run_program();
    clear_prog();
    prog[0] = enc_i(12'd5, 5'd0, 3'd0, 5'd1);
    prog[1] = 32'h1234_507f;
    run_program();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/insn_decode.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/reg_file.sv
logic/sequencer.sv
logic/rv_core.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --timing -Wno-fatal \
  -f sim.f --top-module rv_core_tb -Mdir obj_dir

# the simulator exits nonzero on failure, the log decides the result
./obj_dir/Vrv_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1
